/* source/swtrace_pkg.sv */
// Software-trace monitor package with data widths, l.nop encodings and event kinds
package swtrace_pkg;

   // Data path width
   // Sizes pc, instruction word, writeback data and the r3 shadow
   localparam int XLEN = 32;

   // Register number width of the OR1K register file
   localparam int REG_ADDR_W = 5;

   // Register carrying the argument of every trace l.nop
   localparam logic [REG_ADDR_W-1:0] TRACE_REG = 5'd3;

   // OR1K l.nop class
   // Major opcode lives in insn[31:26], sub-field insn[25:24] reads 01
   localparam logic [5:0] NOP_MAJOR = 6'h05;
   localparam logic [1:0] NOP_SUB = 2'b01;

   // Bit positions inside the instruction word
   localparam int NOP_MAJOR_LSB = 26;
   localparam int NOP_SUB_LSB = 24;
   localparam int NOP_K_W = 16;

   // Immediates that mark the trace instructions
   // Any other immediate is an ordinary no-op
   localparam logic [NOP_K_W-1:0] NOP_K_EXIT = 16'd1;
   localparam logic [NOP_K_W-1:0] NOP_K_REPORT = 16'd2;
   localparam logic [NOP_K_W-1:0] NOP_K_PUTC = 16'd4;

   // Width of a putc character
   localparam int CHAR_W = 8;

   // Kind of a decoded software-trace event
   // EV_NONE doubles as the idle value of every event strobe
   typedef enum logic [1:0] {
      EV_NONE = 2'd0,
      EV_EXIT = 2'd1,
      EV_REPORT = 2'd2,
      EV_PUTC = 2'd3
   } ev_kind_e;

endpackage

/* source/trace_r3_shadow.sv */
// Trace stage 1, registers a retired instruction of one core with its r3 shadow value
module trace_r3_shadow (
   input  logic                                     clk,
   input  logic                                     rst_n_i,

   // Retired instruction strobe of the core
   input  logic                                     trace_valid_i,
   input  logic [swtrace_pkg::XLEN-1:0]             trace_insn_i,
   input  logic                                     trace_wben_i,
   input  logic [swtrace_pkg::REG_ADDR_W-1:0]       trace_wbreg_i,
   input  logic [swtrace_pkg::XLEN-1:0]             trace_wbdata_i,

   // Registered instruction towards the decoder
   output logic                                     s1_valid_o,
   output logic [swtrace_pkg::XLEN-1:0]             s1_insn_o,
   output logic [swtrace_pkg::XLEN-1:0]             s1_r3_o
);

   import swtrace_pkg::*;

   // Shadow copy of r3 as seen after the last retired instruction
   logic [XLEN-1:0] r3_q;
   logic r3_wr;

   // Only a valid, enabled writeback to r3 touches the shadow
   assign r3_wr = trace_valid_i && trace_wben_i && (trace_wbreg_i == TRACE_REG);

   // Control state, strobe and shadow
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r3_q <= '0;
         s1_valid_o <= 1'b0;
      end else begin
         s1_valid_o <= trace_valid_i;
         // New value is visible to the next instruction only
         if (r3_wr) begin
            r3_q <= trace_wbdata_i;
         end
      end
   end

   // Payload of the stage
   // r3 sampled before this instruction's own writeback lands
   always_ff @(posedge clk) begin
      if (trace_valid_i) begin
         s1_insn_o <= trace_insn_i;
         s1_r3_o <= r3_q;
      end
   end

endmodule

/* source/nop_event_decoder.sv */
// Trace stage 2, decodes exit, report and putc l.nop instructions of one core
module nop_event_decoder (
   input  logic                                     clk,
   input  logic                                     rst_n_i,

   // Registered instruction from stage 1
   input  logic                                     s1_valid_i,
   input  logic [swtrace_pkg::XLEN-1:0]             s1_insn_i,
   input  logic [swtrace_pkg::XLEN-1:0]             s1_r3_i,

   // Decoded event, kind other than EV_NONE is the strobe
   output swtrace_pkg::ev_kind_e                    s2_kind_o,
   output logic [swtrace_pkg::XLEN-1:0]             s2_arg_o
);

   import swtrace_pkg::*;

   logic is_nop;
   logic [NOP_K_W-1:0] nop_k;
   ev_kind_e kind_d;
   logic [XLEN-1:0] arg_d;

   // Major opcode plus sub-field identify the l.nop class
   assign is_nop = s1_valid_i
                   && (s1_insn_i[NOP_MAJOR_LSB +: 6] == NOP_MAJOR)
                   && (s1_insn_i[NOP_SUB_LSB +: 2] == NOP_SUB);

   // Immediate sits in the low half of the word
   assign nop_k = s1_insn_i[NOP_K_W-1:0];

   // Map immediate to event kind and pick the argument
   always_comb begin
      kind_d = EV_NONE;
      arg_d = s1_r3_i;
      if (is_nop) begin
         case (nop_k)
            NOP_K_EXIT: begin
               kind_d = EV_EXIT;
            end
            NOP_K_REPORT: begin
               kind_d = EV_REPORT;
            end
            NOP_K_PUTC: begin
               kind_d = EV_PUTC;
               // Character is the low byte, zero-extended
               arg_d = {{(XLEN-CHAR_W){1'b0}}, s1_r3_i[CHAR_W-1:0]};
            end
            default: begin
               kind_d = EV_NONE;
            end
         endcase
      end
   end

   // Event strobe
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s2_kind_o <= EV_NONE;
      end else begin
         s2_kind_o <= kind_d;
      end
   end

   // Argument only matters together with an event
   always_ff @(posedge clk) begin
      if (kind_d != EV_NONE) begin
         s2_arg_o <= arg_d;
      end
   end

endmodule

/* source/event_merge.sv */
// Trace stage 3, buffers report and putc events per core and merges them round-robin
module event_merge #(
   parameter int NUM_CORES = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                              clk,
   input  logic                                              rst_n_i,

   // Decoded events of all cores
   input  swtrace_pkg::ev_kind_e [NUM_CORES-1:0]             s2_kind_i,
   input  logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]       s2_arg_i,

   // Merged event stream, no back-pressure
   output logic                                              ev_valid_o,
   output logic [$clog2(NUM_CORES)-1:0]                      ev_core_o,
   output swtrace_pkg::ev_kind_e                             ev_kind_o,
   output logic [swtrace_pkg::XLEN-1:0]                      ev_data_o,
   output logic                                              overflow_o
);

   import swtrace_pkg::*;

   localparam int CORE_W = $clog2(NUM_CORES);
   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // Per-core buffer status seen by the arbiter
   logic [NUM_CORES-1:0] avail;
   logic [NUM_CORES-1:0] grant;
   logic [NUM_CORES-1:0] drop;
   ev_kind_e head_kind [NUM_CORES];
   logic [XLEN-1:0] head_data [NUM_CORES];

   // Round-robin state, last core served
   logic [CORE_W-1:0] last_q;
   logic [CORE_W-1:0] grant_idx;
   logic grant_any;

   for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
      ev_kind_e kind_mem [FIFO_DEPTH];
      logic [XLEN-1:0] data_mem [FIFO_DEPTH];
      // Extra pointer bit tells full from empty
      logic [PTR_W:0] wr_ptr;
      logic [PTR_W:0] rd_ptr;
      logic in_ev;
      logic empty;
      logic full;
      logic pop;
      logic push;
      logic wr_en;

      // Exits are handled by the tracker only
      assign in_ev = (s2_kind_i[c] == EV_REPORT) || (s2_kind_i[c] == EV_PUTC);
      assign empty = (wr_ptr == rd_ptr);
      assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                    && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

      // Incoming event competes directly while the buffer is empty
      assign avail[c] = !empty || in_ev;
      assign head_kind[c] = empty ? s2_kind_i[c] : kind_mem[rd_ptr[PTR_W-1:0]];
      assign head_data[c] = empty ? s2_arg_i[c] : data_mem[rd_ptr[PTR_W-1:0]];

      // Bypassed event never enters the buffer
      assign pop = grant[c] && !empty;
      assign push = in_ev && !(empty && grant[c]);
      // A slot freed in the same cycle may be reused
      assign wr_en = push && (!full || pop);
      assign drop[c] = push && !wr_en;

      always_ff @(posedge clk or negedge rst_n_i) begin
         if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
         end else begin
            if (wr_en) begin
               wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
      end

      always_ff @(posedge clk) begin
         if (wr_en) begin
            kind_mem[wr_ptr[PTR_W-1:0]] <= s2_kind_i[c];
            data_mem[wr_ptr[PTR_W-1:0]] <= s2_arg_i[c];
         end
      end
   end

   // Search starts at the core after the one served last
   always_comb begin : p_arb
      int idx;
      grant_any = 1'b0;
      grant_idx = last_q;
      for (int k = 1; k <= NUM_CORES; k++) begin
         idx = int'(last_q) + k;
         if (idx >= NUM_CORES) begin
            idx = idx - NUM_CORES;
         end
         if (!grant_any && avail[idx]) begin
            grant_any = 1'b1;
            grant_idx = CORE_W'(idx);
         end
      end
      grant = '0;
      grant[grant_idx] = grant_any;
   end

   // Strobe, arbiter state and sticky overflow
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ev_valid_o <= 1'b0;
         overflow_o <= 1'b0;
         // Core 0 wins the first round
         last_q <= CORE_W'(NUM_CORES - 1);
      end else begin
         ev_valid_o <= grant_any;
         overflow_o <= overflow_o || (|drop);
         if (grant_any) begin
            last_q <= grant_idx;
         end
      end
   end

   // Granted event payload
   always_ff @(posedge clk) begin
      if (grant_any) begin
         ev_core_o <= grant_idx;
         ev_kind_o <= head_kind[grant_idx];
         ev_data_o <= head_data[grant_idx];
      end
   end

endmodule

/* source/termination_tracker.sv */
// Exit tracker, keeps the first exit code of each core and flags when all cores exited
module termination_tracker #(
   parameter int NUM_CORES = 4
) (
   input  logic                                              clk,
   input  logic                                              rst_n_i,

   // Decoded events of all cores, only EV_EXIT matters here
   input  swtrace_pkg::ev_kind_e [NUM_CORES-1:0]             s2_kind_i,
   input  logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]       s2_arg_i,

   // Per-core exit state
   output logic [NUM_CORES-1:0]                              exited_o,
   output logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]       exit_code_o,
   // End-of-simulation condition of the full system
   output logic                                              all_exited_o
);

   import swtrace_pkg::*;

   // First exit of each core in this cycle
   logic [NUM_CORES-1:0] exit_hit;
   logic [NUM_CORES-1:0] exited_d;

   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         // Repeated exits of an exited core are ignored
         exit_hit[c] = (s2_kind_i[c] == EV_EXIT) && !exited_o[c];
      end
   end

   assign exited_d = exited_o | exit_hit;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exited_o <= '0;
         exit_code_o <= '0;
         all_exited_o <= 1'b0;
      end else begin
         exited_o <= exited_d;
         for (int c = 0; c < NUM_CORES; c++) begin
            if (exit_hit[c]) begin
               exit_code_o[c] <= s2_arg_i[c];
            end
         end
         // Rises in the same cycle as the last exited bit
         all_exited_o <= &exited_d;
      end
   end

endmodule

/* source/swtrace_monitor.sv */
// Software-trace monitor top, per-core shadow and decode stages feeding merge and exit tracker
module swtrace_monitor #(
   parameter int NUM_CORES = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                                    clk,
   input  logic                                                    rst_n_i,

   // Core trace ports, one slice per core
   input  logic [NUM_CORES-1:0]                                    trace_valid_i,
   // Accepted for port compatibility, no stage needs the pc
   input  logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]             trace_pc_i,
   input  logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]             trace_insn_i,
   input  logic [NUM_CORES-1:0]                                    trace_wben_i,
   input  logic [NUM_CORES-1:0][swtrace_pkg::REG_ADDR_W-1:0]       trace_wbreg_i,
   input  logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]             trace_wbdata_i,

   // Merged print and report stream
   output logic                                                    ev_valid_o,
   output logic [$clog2(NUM_CORES)-1:0]                            ev_core_o,
   output swtrace_pkg::ev_kind_e                                   ev_kind_o,
   output logic [swtrace_pkg::XLEN-1:0]                            ev_data_o,
   output logic                                                    overflow_o,

   // Termination state
   output logic [NUM_CORES-1:0]                                    exited_o,
   output logic [NUM_CORES-1:0][swtrace_pkg::XLEN-1:0]             exit_code_o,
   output logic                                                    all_exited_o
);

   import swtrace_pkg::*;

   // Stage 1 to stage 2
   logic [NUM_CORES-1:0] s1_valid;
   logic [NUM_CORES-1:0][XLEN-1:0] s1_insn;
   logic [NUM_CORES-1:0][XLEN-1:0] s1_r3;

   // Stage 2 to merge and tracker
   ev_kind_e [NUM_CORES-1:0] s2_kind;
   logic [NUM_CORES-1:0][XLEN-1:0] s2_arg;

   for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
      trace_r3_shadow trace_r3_shadow_i (
         .clk            (clk),
         .rst_n_i        (rst_n_i),
         .trace_valid_i  (trace_valid_i[c]),
         .trace_insn_i   (trace_insn_i[c]),
         .trace_wben_i   (trace_wben_i[c]),
         .trace_wbreg_i  (trace_wbreg_i[c]),
         .trace_wbdata_i (trace_wbdata_i[c]),
         .s1_valid_o     (s1_valid[c]),
         .s1_insn_o      (s1_insn[c]),
         .s1_r3_o        (s1_r3[c])
      );

      nop_event_decoder nop_event_decoder_i (
         .clk        (clk),
         .rst_n_i    (rst_n_i),
         .s1_valid_i (s1_valid[c]),
         .s1_insn_i  (s1_insn[c]),
         .s1_r3_i    (s1_r3[c]),
         .s2_kind_o  (s2_kind[c]),
         .s2_arg_o   (s2_arg[c])
      );
   end

   // Variable latency path to the output stream
   event_merge #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) event_merge_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .s2_kind_i  (s2_kind),
      .s2_arg_i   (s2_arg),
      .ev_valid_o (ev_valid_o),
      .ev_core_o  (ev_core_o),
      .ev_kind_o  (ev_kind_o),
      .ev_data_o  (ev_data_o),
      .overflow_o (overflow_o)
   );

   // Fixed one-cycle path for exits
   termination_tracker #(
      .NUM_CORES (NUM_CORES)
   ) termination_tracker_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .s2_kind_i    (s2_kind),
      .s2_arg_i     (s2_arg),
      .exited_o     (exited_o),
      .exit_code_o  (exit_code_o),
      .all_exited_o (all_exited_o)
   );

endmodule

/* bench/tb_swtrace_monitor.sv */
// Testbench for the software-trace monitor driving LFSR stimulus against a per-core reference model
module tb_swtrace_monitor;

   timeunit 1ns;
   timeprecision 1ps;

   import swtrace_pkg::*;

   localparam int NUM_CORES = 4;
   localparam int FIFO_DEPTH = 4;

   logic clk;
   logic rst_n_i;
   logic [NUM_CORES-1:0] trace_valid;
   logic [NUM_CORES-1:0][XLEN-1:0] trace_pc;
   logic [NUM_CORES-1:0][XLEN-1:0] trace_insn;
   logic [NUM_CORES-1:0] trace_wben;
   logic [NUM_CORES-1:0][REG_ADDR_W-1:0] trace_wbreg;
   logic [NUM_CORES-1:0][XLEN-1:0] trace_wbdata;
   logic ev_valid_o;
   logic [$clog2(NUM_CORES)-1:0] ev_core_o;
   ev_kind_e ev_kind_o;
   logic [XLEN-1:0] ev_data_o;
   logic overflow_o;
   logic [NUM_CORES-1:0] exited_o;
   logic [NUM_CORES-1:0][XLEN-1:0] exit_code_o;
   logic all_exited_o;

   // Reference model state owned by the checker process
   logic [XLEN-1:0] shadow [NUM_CORES];
   logic [XLEN+1:0] exp_q [NUM_CORES][$];
   logic [NUM_CORES-1:0] m_exited;
   logic [NUM_CORES-1:0][XLEN-1:0] m_codes;
   // Model exit state delayed to line up with the tracker outputs
   logic [NUM_CORES-1:0] pipe_exited [3];
   logic [NUM_CORES-1:0][XLEN-1:0] pipe_codes [3];
   logic ovf_seen;
   int value_errors = 0;
   int other_errors = 0;
   int events_seen = 0;

   // Stimulus control owned by the stimulus process
   logic allow_gaps;
   logic expect_overflow;
   logic [31:0] lfsr_q = 32'h430d_a483;
   logic [XLEN-1:0] pc_cnt;

   swtrace_monitor #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) swtrace_monitor_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .trace_valid_i  (trace_valid),
      .trace_pc_i     (trace_pc),
      .trace_insn_i   (trace_insn),
      .trace_wben_i   (trace_wben),
      .trace_wbreg_i  (trace_wbreg),
      .trace_wbdata_i (trace_wbdata),
      .ev_valid_o     (ev_valid_o),
      .ev_core_o      (ev_core_o),
      .ev_kind_o      (ev_kind_o),
      .ev_data_o      (ev_data_o),
      .overflow_o     (overflow_o),
      .exited_o       (exited_o),
      .exit_code_o    (exit_code_o),
      .all_exited_o   (all_exited_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic fb;
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [31:0] nop_insn(input logic [15:0] k);
      return {NOP_MAJOR, NOP_SUB, 8'h00, k};
   endfunction

   // Random word kept out of the l.nop class
   function automatic logic [31:0] alu_insn();
      logic [31:0] insn;
      insn = take_bits(32);
      if (insn[31:26] == NOP_MAJOR) begin
         insn[31] = ~insn[31];
      end
      return insn;
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      value_errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("Summary: %0d value mismatches, %0d other failures, %0d events checked",
               value_errors, other_errors, events_seen);
   endtask

   // Inputs change 10 ns after the rising edge and strobes last one cycle
   task automatic next_cycle();
      @(posedge clk);
      #10;
      trace_valid = '0;
      trace_wben = '0;
   endtask

   task automatic retire(input int c, input logic [31:0] insn, input logic wben,
                         input logic [REG_ADDR_W-1:0] reg_n, input logic [31:0] data);
      trace_valid[c] = 1'b1;
      trace_pc[c] = pc_cnt;
      pc_cnt = pc_cnt + 32'd4;
      trace_insn[c] = insn;
      trace_wben[c] = wben;
      trace_wbreg[c] = reg_n;
      trace_wbdata[c] = data;
   endtask

   task automatic write_r3(input int c, input logic [31:0] data);
      retire(c, alu_insn(), 1'b1, TRACE_REG, data);
   endtask

   task automatic apply_reset();
      next_cycle();
      rst_n_i = 1'b0;
      allow_gaps = 1'b0;
      expect_overflow = 1'b0;
      repeat (16) @(posedge clk);
      #10;
      rst_n_i = 1'b1;
   endtask

   // All expected events delivered
   task automatic wait_drained(input string what);
      int n;
      logic done;
      done = 1'b0;
      for (n = 0; n < 200 && !done; n++) begin
         next_cycle();
         done = (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size()) == 0;
      end
      if (!done) begin
         report_problem($sformatf("timeout while %s", what));
      end
   endtask

   // Output stream quiet for eight cycles in a row
   task automatic wait_idle();
      int n;
      int idle;
      idle = 0;
      for (n = 0; n < 200 && idle < 8; n++) begin
         next_cycle();
         idle = ev_valid_o ? 0 : idle + 1;
      end
      if (idle < 8) begin
         report_problem("timeout while waiting for the merged stream to go idle");
      end
   endtask

   task automatic wait_all_exited();
      int n;
      for (n = 0; n < 20 && !all_exited_o; n++) begin
         next_cycle();
      end
      if (!all_exited_o) begin
         report_problem("timeout while waiting for all_exited_o");
      end
   endtask

   // Checks at the falling edge before the model takes the strobes of the next rising edge
   always @(negedge clk) begin : check_and_model
      int c;
      int k;
      logic [XLEN+1:0] item;
      logic found;
      logic [31:0] insn;
      if (!rst_n_i) begin
         for (c = 0; c < NUM_CORES; c++) begin
            shadow[c] = '0;
            exp_q[c].delete();
         end
         m_exited = '0;
         m_codes = '0;
         for (k = 0; k < 3; k++) begin
            pipe_exited[k] = '0;
            pipe_codes[k] = '0;
         end
         ovf_seen = 1'b0;
      end else begin
         if (ev_valid_o) begin
            events_seen++;
            if (exp_q[ev_core_o].size() == 0) begin
               report_problem($sformatf("unexpected event from core %0d", ev_core_o));
            end else if (allow_gaps) begin
               // Dropped events leave holes but order must still hold
               found = 1'b0;
               while (!found && exp_q[ev_core_o].size() > 0) begin
                  item = exp_q[ev_core_o].pop_front();
                  found = (ev_kind_o == ev_kind_e'(item[33:32])) && (ev_data_o == item[31:0]);
               end
               if (!found) begin
                  report_problem($sformatf("event of core %0d matches no pending event",
                                           ev_core_o));
               end
            end else begin
               item = exp_q[ev_core_o].pop_front();
               assert (ev_kind_o == ev_kind_e'(item[33:32]))
                  else report_mismatch("ev_kind_o", 32'(item[33:32]), 32'(ev_kind_o));
               assert (ev_data_o == item[31:0])
                  else report_mismatch("ev_data_o", item[31:0], ev_data_o);
            end
         end
         if (!allow_gaps) begin
            assert (!overflow_o) else report_mismatch("overflow_o", 32'd0, 32'(overflow_o));
         end
         // Sticky until reset
         if (ovf_seen || expect_overflow) begin
            assert (overflow_o) else report_mismatch("overflow_o", 32'd1, 32'(overflow_o));
         end
         if (overflow_o) begin
            ovf_seen = 1'b1;
         end
         assert (exited_o == pipe_exited[2])
            else report_mismatch("exited_o", 32'(pipe_exited[2]), 32'(exited_o));
         assert (all_exited_o == &pipe_exited[2])
            else report_mismatch("all_exited_o", 32'(&pipe_exited[2]), 32'(all_exited_o));
         for (c = 0; c < NUM_CORES; c++) begin
            assert (exit_code_o[c] == pipe_codes[2][c])
               else report_mismatch($sformatf("exit_code_o[%0d]", c), pipe_codes[2][c],
                                    exit_code_o[c]);
         end
         for (k = 2; k > 0; k--) begin
            pipe_exited[k] = pipe_exited[k-1];
            pipe_codes[k] = pipe_codes[k-1];
         end
         for (c = 0; c < NUM_CORES; c++) begin
            if (trace_valid[c]) begin
               insn = trace_insn[c];
               if (insn[31:26] == NOP_MAJOR && insn[25:24] == NOP_SUB) begin
                  if (insn[15:0] == NOP_K_PUTC) begin
                     exp_q[c].push_back({EV_PUTC, 24'h0, shadow[c][7:0]});
                  end else if (insn[15:0] == NOP_K_REPORT) begin
                     exp_q[c].push_back({EV_REPORT, shadow[c]});
                  end else if (insn[15:0] == NOP_K_EXIT && !m_exited[c]) begin
                     m_exited[c] = 1'b1;
                     m_codes[c] = shadow[c];
                  end
               end
               // Own writeback counts only for later instructions
               if (trace_wben[c] && trace_wbreg[c] == TRACE_REG) begin
                  shadow[c] = trace_wbdata[c];
               end
            end
         end
         pipe_exited[0] = m_exited;
         pipe_codes[0] = m_codes;
      end
   end

   initial begin : stimulus
      int n;
      int c;
      logic [REG_ADDR_W-1:0] reg_n;
      logic [31:0] data;
      rst_n_i = 1'b0;
      trace_valid = '0;
      trace_pc = '0;
      trace_insn = '0;
      trace_wben = '0;
      trace_wbreg = '0;
      trace_wbdata = '0;
      allow_gaps = 1'b0;
      expect_overflow = 1'b0;
      pc_cnt = 32'h0000_1000;
      repeat (16) @(posedge clk);
      #10;
      rst_n_i = 1'b1;

      // Putc mix on one random core per cycle
      for (n = 0; n < 64; n++) begin
         next_cycle();
         c = int'(take_bits(2));
         data = take_bits(32);
         if (take_bits(1) != 0) begin
            retire(c, nop_insn(NOP_K_PUTC), 1'b0, 5'd0, 32'd0);
         end else begin
            write_r3(c, data);
         end
      end
      wait_drained("draining putc events");

      // Report with writebacks that must not reach r3
      for (n = 0; n < 3 * NUM_CORES; n++) begin
         c = n % NUM_CORES;
         next_cycle();
         write_r3(c, take_bits(32));
         next_cycle();
         reg_n = REG_ADDR_W'(take_bits(5));
         if (reg_n == TRACE_REG) begin
            reg_n = 5'd4;
         end
         retire(c, alu_insn(), 1'b1, reg_n, take_bits(32));
         next_cycle();
         retire(c, alu_insn(), 1'b0, TRACE_REG, take_bits(32));
         next_cycle();
         retire(c, nop_insn(NOP_K_REPORT), 1'b0, 5'd0, 32'd0);
      end
      wait_drained("draining report events");

      // Silent traffic on all cores and then one core at full putc rate
      for (n = 0; n < 48; n++) begin
         next_cycle();
         for (c = 0; c < NUM_CORES; c++) begin
            if (take_bits(1) != 0) begin
               retire(c, nop_insn(16'(take_bits(16)) | 16'h0100), 1'b0, 5'd0, 32'd0);
            end else begin
               retire(c, alu_insn(), take_bits(1) != 0, REG_ADDR_W'(take_bits(5)),
                      take_bits(32));
            end
         end
      end
      for (c = 0; c < NUM_CORES; c++) begin
         for (n = 0; n < 3 * FIFO_DEPTH; n++) begin
            next_cycle();
            retire(c, nop_insn(NOP_K_PUTC), 1'b1, TRACE_REG, take_bits(32));
         end
      end
      wait_drained("draining single-core putc burst");

      // Exit twice per core where the second code is ignored
      for (c = 0; c < NUM_CORES; c++) begin
         next_cycle();
         write_r3(c, take_bits(32));
         next_cycle();
         retire(c, nop_insn(NOP_K_EXIT), 1'b0, 5'd0, 32'd0);
         next_cycle();
         write_r3(c, take_bits(32));
         next_cycle();
         retire(c, nop_insn(NOP_K_EXIT), 1'b0, 5'd0, 32'd0);
      end
      wait_all_exited();

      // All cores at full putc rate overrun the buffers
      allow_gaps = 1'b1;
      for (n = 0; n < 4 * FIFO_DEPTH; n++) begin
         next_cycle();
         for (c = 0; c < NUM_CORES; c++) begin
            retire(c, nop_insn(NOP_K_PUTC), 1'b1, TRACE_REG, take_bits(32));
         end
      end
      wait_idle();
      expect_overflow = 1'b1;
      repeat (8) next_cycle();

      // Reset clears overflow and exit state before normal traffic resumes
      apply_reset();
      next_cycle();
      write_r3(1, take_bits(32));
      next_cycle();
      retire(1, nop_insn(NOP_K_PUTC), 1'b0, 5'd0, 32'd0);
      retire(2, nop_insn(NOP_K_REPORT), 1'b0, 5'd0, 32'd0);
      wait_drained("draining events after reset");
      repeat (8) next_cycle();

      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* flist.f */
source/swtrace_pkg.sv
source/trace_r3_shadow.sv
source/nop_event_decoder.sv
source/event_merge.sv
source/termination_tracker.sv
source/swtrace_monitor.sv
bench/tb_swtrace_monitor.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_swtrace_monitor
FLIST     := flist.f
BUILD_DIR := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
